// File: hw/bus_config.svh
`ifndef BUS_CONFIG_SVH
`define BUS_CONFIG_SVH

// core side widths
`define ADDR_W 32
`define DATA_W 32
`define STRB_W 4

// bus side widths
`define BUS_DATA_W 64
`define BUS_STRB_W 8
`define AXI_ID_W 4

// machine timer words
`define MTIME_ADDR    32'h0200_BFF8
`define MTIME_ADDR_HI 32'h0200_BFFC

`endif

// File: hw/axi_pkg.sv
`include "bus_config.svh"
`default_nettype none

package axi_pkg;

  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } axi_resp_e;

  localparam logic [1:0] BURST_INCR = 2'b01;

  typedef struct packed {
    logic [`ADDR_W-1:0]   addr;
    logic [7:0]           len;
    logic [2:0]           size;
    logic [1:0]           burst;
    logic [`AXI_ID_W-1:0] id;
  } axi_ar_t;

  typedef struct packed {
    logic [`ADDR_W-1:0]   addr;
    logic [7:0]           len;
    logic [2:0]           size;
    logic [1:0]           burst;
    logic [`AXI_ID_W-1:0] id;
  } axi_aw_t;

  typedef struct packed {
    logic [`BUS_DATA_W-1:0] data;
    logic [`BUS_STRB_W-1:0] strb;
    logic                   last;
  } axi_w_t;

  typedef struct packed {
    logic [`BUS_DATA_W-1:0] data;
    axi_resp_e              resp;
    logic                   last;
    logic [`AXI_ID_W-1:0]   id;
  } axi_r_t;

  typedef struct packed {
    axi_resp_e            resp;
    logic [`AXI_ID_W-1:0] id;
  } axi_b_t;

endpackage

`default_nettype wire

// File: hw/core_bus_pkg.sv
`include "bus_config.svh"
`default_nettype none

package core_bus_pkg;

  typedef enum logic [2:0] {
    SZ_BYTE = 3'd0,
    SZ_HALF = 3'd1,
    SZ_WORD = 3'd2
  } axi_size_e;

  typedef enum logic [2:0] {
    ARB_IDLE,
    ARB_RD_ADDR,
    ARB_RD_DATA,
    ARB_TIMER,
    ARB_WR_ADDR,
    ARB_WR_RESP
  } arb_state_e;

  typedef struct packed {
    logic [`ADDR_W-1:0] addr;
    logic               valid;  // level, held until response
  } fetch_req_t;

  typedef struct packed {
    logic [`ADDR_W-1:0] addr;
    logic [`STRB_W-1:0] strb;
    logic               valid;
  } load_req_t;

  typedef struct packed {
    logic [`ADDR_W-1:0] addr;
    logic [`DATA_W-1:0] data;
    logic [`STRB_W-1:0] strb;
    logic               valid;
  } store_req_t;

  typedef struct packed {
    logic [`DATA_W-1:0] data;
    logic               valid;  // one cycle pulse
  } core_rsp_t;

endpackage

`default_nettype wire

// File: hw/clint_timer.sv
`include "bus_config.svh"
`default_nettype none

module clint_timer
(
  input  wire logic               clk,
  input  wire logic               rst,
  input  wire logic               rd_en_i,
  input  wire logic               rd_hi_i,
  output logic      [`DATA_W-1:0] rdata_o,
  output logic                    rvalid_o
);

  logic [2*`DATA_W-1:0] mtime_q;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      mtime_q  <= '0;
      rvalid_o <= 1'b0;
    end
    else
    begin
      mtime_q  <= mtime_q + 1'b1;  // free running
      rvalid_o <= rd_en_i;
    end
  end

  // word select on the read strobe
  always_ff @(posedge clk)
  begin
    if (rd_en_i)
      rdata_o <= rd_hi_i ? mtime_q[`DATA_W +: `DATA_W] : mtime_q[`DATA_W-1:0];
  end

endmodule

`default_nettype wire

// File: hw/lane_align.sv
`include "bus_config.svh"
`default_nettype none

module lane_align
(
  input  wire logic [`ADDR_W-1:0]     addr_i,
  input  wire logic [`STRB_W-1:0]     strb_i,
  input  wire logic [`DATA_W-1:0]     wdata_i,
  input  wire logic [`BUS_DATA_W-1:0] rdata_i,
  output core_bus_pkg::axi_size_e     size_o,
  output logic      [`BUS_DATA_W-1:0] wdata_o,
  output logic      [`BUS_STRB_W-1:0] wstrb_o,
  output logic      [`DATA_W-1:0]     rdata_o
);

  import core_bus_pkg::*;

  logic [1:0]         off;
  logic [`DATA_W-1:0] wdata_sh;
  logic [`STRB_W-1:0] strb_sh;
  logic [`DATA_W-1:0] rhalf;

  assign off = addr_i[1:0];

  always_comb
  begin
    case (strb_i)
      4'b0001: size_o = SZ_BYTE;
      4'b0011: size_o = SZ_HALF;
      4'b1111: size_o = SZ_WORD;
      default: size_o = SZ_BYTE;
    endcase
  end

  // write side
  assign wdata_sh = wdata_i << {off, 3'b000};
  assign wdata_o  = {wdata_sh, wdata_sh};  // same word on both halves
  assign strb_sh  = strb_i << off;         // bytes past the word drop off
  assign wstrb_o  = addr_i[2] ? {strb_sh, {`STRB_W{1'b0}}} : {{`STRB_W{1'b0}}, strb_sh};

  // addressed byte lands in bits 7:0
  assign rhalf   = addr_i[2] ? rdata_i[`BUS_DATA_W-1:`DATA_W] : rdata_i[`DATA_W-1:0];
  assign rdata_o = rhalf >> {off, 3'b000};

endmodule

`default_nettype wire

// File: hw/mem_arbiter.sv
`include "bus_config.svh"
`default_nettype none

module mem_arbiter
(
  input  wire logic                     clk,
  input  wire logic                     rst,
  input  wire core_bus_pkg::fetch_req_t fetch_req_i,
  input  wire core_bus_pkg::load_req_t  load_req_i,
  input  wire core_bus_pkg::store_req_t store_req_i,
  output core_bus_pkg::core_rsp_t       fetch_rsp_o,
  output core_bus_pkg::core_rsp_t       load_rsp_o,
  output logic                          store_done_o,
  output logic                          bus_err_o,
  output axi_pkg::axi_ar_t              bus_ar_o,
  output logic                          bus_arvalid_o,
  input  wire logic                     bus_arready_i,
  input  wire axi_pkg::axi_r_t          bus_r_i,
  input  wire logic                     bus_rvalid_i,
  output logic                          bus_rready_o,
  output axi_pkg::axi_aw_t              bus_aw_o,
  output logic                          bus_awvalid_o,
  input  wire logic                     bus_awready_i,
  output axi_pkg::axi_w_t               bus_w_o,
  output logic                          bus_wvalid_o,
  input  wire logic                     bus_wready_i,
  input  wire axi_pkg::axi_b_t          bus_b_i,
  input  wire logic                     bus_bvalid_i,
  output logic                          bus_bready_o
);

  import axi_pkg::*;
  import core_bus_pkg::*;

  arb_state_e             state_q;
  logic [`ADDR_W-1:0]     addr_q;
  logic [`DATA_W-1:0]     wdata_q;
  logic [`STRB_W-1:0]     strb_q;
  logic                   owner_q;  // 1 = load/store
  logic                   aw_done_q;
  logic                   w_done_q;
  logic                   tmr_rd_q;
  logic                   aw_ok;
  logic                   w_ok;
  logic                   ld_is_tmr;
  logic                   rd_beat;
  logic                   b_beat;
  axi_size_e              xfer_size;
  logic [`BUS_DATA_W-1:0] bus_wdata;
  logic [`BUS_STRB_W-1:0] bus_wstrb;
  logic [`DATA_W-1:0]     bus_rdata;
  logic [`DATA_W-1:0]     tmr_rdata;
  logic                   tmr_rvalid;

  assign ld_is_tmr = (load_req_i.addr == `MTIME_ADDR) || (load_req_i.addr == `MTIME_ADDR_HI);
  assign aw_ok     = aw_done_q || (bus_awvalid_o && bus_awready_i);
  assign w_ok      = w_done_q || (bus_wvalid_o && bus_wready_i);
  assign rd_beat   = (state_q == ARB_RD_DATA) && bus_rvalid_i;
  assign b_beat    = (state_q == ARB_WR_RESP) && bus_bvalid_i;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q   <= ARB_IDLE;
      owner_q   <= 1'b0;
      aw_done_q <= 1'b0;
      w_done_q  <= 1'b0;
      tmr_rd_q  <= 1'b0;
    end
    else
    begin
      tmr_rd_q <= 1'b0;
      case (state_q)
        ARB_IDLE:
        begin
          if (store_req_i.valid)
          begin
            state_q <= ARB_WR_ADDR;
            owner_q <= 1'b1;
          end
          else if (load_req_i.valid)
          begin
            owner_q  <= 1'b1;
            state_q  <= ld_is_tmr ? ARB_TIMER : ARB_RD_ADDR;
            tmr_rd_q <= ld_is_tmr;  // timer strobe one cycle late
          end
          else if (fetch_req_i.valid)
          begin
            state_q <= ARB_RD_ADDR;
            owner_q <= 1'b0;
          end
        end
        ARB_RD_ADDR:
          if (bus_arready_i)
            state_q <= ARB_RD_DATA;
        ARB_RD_DATA:
          if (bus_rvalid_i)
            state_q <= ARB_IDLE;
        ARB_TIMER:
          if (tmr_rvalid)
            state_q <= ARB_IDLE;
        ARB_WR_ADDR:
        begin
          aw_done_q <= aw_ok;
          w_done_q  <= w_ok;
          if (aw_ok && w_ok)
          begin
            state_q   <= ARB_WR_RESP;
            aw_done_q <= 1'b0;
            w_done_q  <= 1'b0;
          end
        end
        ARB_WR_RESP:
          if (bus_bvalid_i)
            state_q <= ARB_IDLE;
        default:
          state_q <= ARB_IDLE;
      endcase
    end
  end

  // capture priority is store then load then fetch
  always_ff @(posedge clk)
  begin
    if (state_q == ARB_IDLE)
    begin
      if (store_req_i.valid)
      begin
        addr_q  <= store_req_i.addr;
        wdata_q <= store_req_i.data;
        strb_q  <= store_req_i.strb;
      end
      else if (load_req_i.valid)
      begin
        addr_q <= load_req_i.addr;
        strb_q <= load_req_i.strb;
      end
      else
      begin
        addr_q <= fetch_req_i.addr;
        strb_q <= '1;  // fetches are whole words
      end
    end
  end

  lane_align u_lane_align (
    .addr_i  (addr_q),
    .strb_i  (strb_q),
    .wdata_i (wdata_q),
    .rdata_i (bus_r_i.data),
    .size_o  (xfer_size),
    .wdata_o (bus_wdata),
    .wstrb_o (bus_wstrb),
    .rdata_o (bus_rdata)
  );

  clint_timer u_clint_timer (
    .clk      (clk),
    .rst      (rst),
    .rd_en_i  (tmr_rd_q),
    .rd_hi_i  (addr_q == `MTIME_ADDR_HI),
    .rdata_o  (tmr_rdata),
    .rvalid_o (tmr_rvalid)
  );

  // bus channels
  assign bus_arvalid_o = (state_q == ARB_RD_ADDR);
  assign bus_awvalid_o = (state_q == ARB_WR_ADDR) && !aw_done_q;
  assign bus_wvalid_o  = (state_q == ARB_WR_ADDR) && !w_done_q;
  assign bus_rready_o  = 1'b1;
  assign bus_bready_o  = 1'b1;

  assign bus_ar_o = '{addr: addr_q, len: 8'd0, size: xfer_size, burst: BURST_INCR, id: '0};
  assign bus_aw_o = '{addr: addr_q, len: 8'd0, size: xfer_size, burst: BURST_INCR, id: '0};
  assign bus_w_o  = '{data: bus_wdata, strb: bus_wstrb, last: bus_wvalid_o};  // single beat

  // responses back to the core
  assign fetch_rsp_o.data  = bus_rdata;
  assign fetch_rsp_o.valid = rd_beat && !owner_q;
  assign load_rsp_o.data   = (state_q == ARB_TIMER) ? tmr_rdata : bus_rdata;
  assign load_rsp_o.valid  = (rd_beat && owner_q) || ((state_q == ARB_TIMER) && tmr_rvalid);
  assign store_done_o      = b_beat;

  assign bus_err_o = (rd_beat && (bus_r_i.resp != OKAY)) || (b_beat && (bus_b_i.resp != OKAY));

endmodule

`default_nettype wire

// File: hw/core_bus_top.sv
`default_nettype none

module core_bus_top
(
  input  wire logic                     clk,
  input  wire logic                     rst,
  input  wire core_bus_pkg::fetch_req_t fetch_req_i,
  input  wire core_bus_pkg::load_req_t  load_req_i,
  input  wire core_bus_pkg::store_req_t store_req_i,
  output core_bus_pkg::core_rsp_t       fetch_rsp_o,
  output core_bus_pkg::core_rsp_t       load_rsp_o,
  output logic                          store_done_o,
  output logic                          bus_err_o,
  output axi_pkg::axi_ar_t              bus_ar_o,
  output logic                          bus_arvalid_o,
  input  wire logic                     bus_arready_i,
  input  wire axi_pkg::axi_r_t          bus_r_i,
  input  wire logic                     bus_rvalid_i,
  output logic                          bus_rready_o,
  output axi_pkg::axi_aw_t              bus_aw_o,
  output logic                          bus_awvalid_o,
  input  wire logic                     bus_awready_i,
  output axi_pkg::axi_w_t               bus_w_o,
  output logic                          bus_wvalid_o,
  input  wire logic                     bus_wready_i,
  input  wire axi_pkg::axi_b_t          bus_b_i,
  input  wire logic                     bus_bvalid_i,
  output logic                          bus_bready_o
);

  mem_arbiter u_mem_arbiter (
    .clk           (clk),
    .rst           (rst),
    .fetch_req_i   (fetch_req_i),
    .load_req_i    (load_req_i),
    .store_req_i   (store_req_i),
    .fetch_rsp_o   (fetch_rsp_o),
    .load_rsp_o    (load_rsp_o),
    .store_done_o  (store_done_o),
    .bus_err_o     (bus_err_o),
    .bus_ar_o      (bus_ar_o),
    .bus_arvalid_o (bus_arvalid_o),
    .bus_arready_i (bus_arready_i),
    .bus_r_i       (bus_r_i),
    .bus_rvalid_i  (bus_rvalid_i),
    .bus_rready_o  (bus_rready_o),
    .bus_aw_o      (bus_aw_o),
    .bus_awvalid_o (bus_awvalid_o),
    .bus_awready_i (bus_awready_i),
    .bus_w_o       (bus_w_o),
    .bus_wvalid_o  (bus_wvalid_o),
    .bus_wready_i  (bus_wready_i),
    .bus_b_i       (bus_b_i),
    .bus_bvalid_i  (bus_bvalid_i),
    .bus_bready_o  (bus_bready_o)
  );

endmodule

`default_nettype wire

// File: verif/bus_checker.sv
`include "bus_config.svh"
`default_nettype none

module bus_checker
(
  input  wire logic                     clk,
  input  wire logic                     rst,
  input  wire core_bus_pkg::fetch_req_t fetch_req_i,
  input  wire core_bus_pkg::load_req_t  load_req_i,
  input  wire core_bus_pkg::store_req_t store_req_i,
  input  wire core_bus_pkg::core_rsp_t  fetch_rsp_i,
  input  wire core_bus_pkg::core_rsp_t  load_rsp_i,
  input  wire logic                     store_done_i,
  input  wire logic                     bus_err_i,
  input  wire axi_pkg::axi_ar_t         ar_i,
  input  wire logic                     arvalid_i,
  input  wire logic                     arready_i,
  input  wire axi_pkg::axi_r_t          r_i,
  input  wire logic                     rvalid_i,
  input  wire logic                     rready_i,
  input  wire axi_pkg::axi_aw_t         aw_i,
  input  wire logic                     awvalid_i,
  input  wire logic                     awready_i,
  input  wire axi_pkg::axi_w_t          w_i,
  input  wire logic                     wvalid_i,
  input  wire logic                     wready_i,
  input  wire axi_pkg::axi_b_t          b_i,
  input  wire logic                     bvalid_i,
  input  wire logic                     bready_i,
  output int                            err_count_o,
  output int                            check_count_o
);

  import axi_pkg::*;
  import core_bus_pkg::*;

  logic [63:0] shadow [0:255];  // memory as seen through completed writes
  int          errors = 0;
  int          checks = 0;
  logic        ar_stall = 1'b0;
  logic        aw_stall = 1'b0;
  logic        w_stall = 1'b0;
  axi_ar_t     ar_prev;
  axi_aw_t     aw_prev;
  axi_w_t      w_prev;
  logic        tmr_busy = 1'b0;
  int          tmr_cycles = 0;
  logic        have_lo = 1'b0;
  logic [31:0] last_lo = '0;

  assign err_count_o   = errors;
  assign check_count_o = checks;

  function automatic logic [63:0] initial_word(input int idx);
    logic [31:0] a;
    a = idx * 8;
    return {(a + 32'd4) * 32'h9E37_79B9, a * 32'h9E37_79B9};
  endfunction

  initial
  begin
    for (int i = 0; i < 256; i++)
      shadow[i] = initial_word(i);
  end

  function automatic logic [2:0] ref_size(input logic [3:0] strb);
    case (strb)
      4'b0011: return 3'd1;
      4'b1111: return 3'd2;
      default: return 3'd0;
    endcase
  endfunction

  // byte k of the core word goes to lane offset+k in each half
  function automatic logic [63:0] ref_wdata(input logic [31:0] addr, input logic [31:0] data);
    logic [63:0] res;
    int          lane;
    res = '0;
    for (int k = 0; k < 4; k++)
    begin
      lane = k + int'(addr[1:0]);
      if (lane < 4)
      begin
        res[8*lane +: 8]      = data[8*k +: 8];
        res[8*lane + 32 +: 8] = data[8*k +: 8];
      end
    end
    return res;
  endfunction

  function automatic logic [7:0] ref_wstrb(input logic [31:0] addr, input logic [3:0] strb);
    logic [7:0] res;
    int         lane;
    res = '0;
    for (int k = 0; k < 4; k++)
    begin
      lane = k + int'(addr[1:0]);
      if (lane < 4 && strb[k])
        res[lane + (addr[2] ? 4 : 0)] = 1'b1;
    end
    return res;
  endfunction

  function automatic logic [31:0] ref_read(input logic [63:0] word, input logic [31:0] addr);
    logic [31:0] half;
    logic [31:0] res;
    int          src;
    half = addr[2] ? word[63:32] : word[31:0];
    res  = '0;
    for (int k = 0; k < 4; k++)
    begin
      src = k + int'(addr[1:0]);
      if (src < 4)
        res[8*k +: 8] = half[8*src +: 8];
    end
    return res;
  endfunction

  task automatic compare_value(input string name, input logic [63:0] exp, input logic [63:0] got);
    checks++;
    if (exp !== got)
    begin
      errors++;
      $display("[ERROR] t=%0t %s expected %h got %h", $time, name, exp, got);
    end
  endtask

  task automatic report_failure(input string msg);
    errors++;
    $display("[ERROR] t=%0t %s", $time, msg);
  endtask

  always @(posedge clk)
  begin
    logic        exp_err;
    logic        ld_tmr;
    logic [63:0] wd;
    logic [7:0]  ws;
    if (!rst)
    begin
      exp_err = (rvalid_i && r_i.resp != OKAY) || (bvalid_i && b_i.resp != OKAY);
      compare_value("bus_err_o", 64'(exp_err), 64'(bus_err_i));
      compare_value("store_done_o", 64'(bvalid_i), 64'(store_done_i));
      compare_value("bus_rready_o", 64'd1, 64'(rready_i));
      compare_value("bus_bready_o", 64'd1, 64'(bready_i));

      if (arvalid_i)
      begin
        compare_value("bus_ar_o.len", 64'd0, 64'(ar_i.len));
        compare_value("bus_ar_o.id", 64'd0, 64'(ar_i.id));
        if (ar_i.addr == `MTIME_ADDR || ar_i.addr == `MTIME_ADDR_HI)
          report_failure("timer address went out on the AR channel");
        else if (load_req_i.valid && ar_i.addr == load_req_i.addr)
          compare_value("bus_ar_o.size", 64'(ref_size(load_req_i.strb)), 64'(ar_i.size));
        else if (fetch_req_i.valid && ar_i.addr == fetch_req_i.addr)
        begin
          if (load_req_i.valid)
            report_failure("fetch address issued while a load was pending");
          compare_value("bus_ar_o.size", 64'(SZ_WORD), 64'(ar_i.size));
        end
        else
          report_failure("AR address matches no pending request");
        if (ar_stall)
          compare_value("bus_ar_o", 64'(ar_prev), 64'(ar_i));
      end
      ar_stall = arvalid_i && !arready_i;
      ar_prev  = ar_i;

      if (awvalid_i)
      begin
        compare_value("bus_aw_o.len", 64'd0, 64'(aw_i.len));
        compare_value("bus_aw_o.id", 64'd0, 64'(aw_i.id));
        if (!store_req_i.valid)
          report_failure("AW valid without a pending store");
        else
        begin
          compare_value("bus_aw_o.addr", 64'(store_req_i.addr), 64'(aw_i.addr));
          compare_value("bus_aw_o.size", 64'(ref_size(store_req_i.strb)), 64'(aw_i.size));
        end
        if (aw_stall)
          compare_value("bus_aw_o", 64'(aw_prev), 64'(aw_i));
      end
      aw_stall = awvalid_i && !awready_i;
      aw_prev  = aw_i;

      if (wvalid_i)
      begin
        compare_value("bus_w_o.last", 64'd1, 64'(w_i.last));
        if (store_req_i.valid)
        begin
          compare_value("bus_w_o.data", ref_wdata(store_req_i.addr, store_req_i.data), w_i.data);
          compare_value("bus_w_o.strb", 64'(ref_wstrb(store_req_i.addr, store_req_i.strb)),
                        64'(w_i.strb));
        end
        if (w_stall)
        begin
          compare_value("bus_w_o.data", w_prev.data, w_i.data);
          compare_value("bus_w_o.strb", 64'(w_prev.strb), 64'(w_i.strb));
        end
      end
      w_stall = wvalid_i && !wready_i;
      w_prev  = w_i;

      // failed writes leave memory alone
      if (bvalid_i && store_req_i.valid && b_i.resp == OKAY)
      begin
        wd = ref_wdata(store_req_i.addr, store_req_i.data);
        ws = ref_wstrb(store_req_i.addr, store_req_i.strb);
        for (int k = 0; k < 8; k++)
          if (ws[k])
            shadow[store_req_i.addr[10:3]][8*k +: 8] = wd[8*k +: 8];
      end

      if (fetch_rsp_i.valid)
      begin
        if (load_req_i.valid)
          report_failure("fetch answered before the pending load");
        compare_value("fetch_rsp_o.data",
                      64'(ref_read(shadow[fetch_req_i.addr[10:3]], fetch_req_i.addr)),
                      64'(fetch_rsp_i.data));
      end

      ld_tmr = load_req_i.valid &&
               (load_req_i.addr == `MTIME_ADDR || load_req_i.addr == `MTIME_ADDR_HI);
      if (ld_tmr)
      begin
        if (!tmr_busy)
        begin
          tmr_busy   = 1'b1;
          tmr_cycles = 0;
        end
        else
          tmr_cycles++;
      end

      if (load_rsp_i.valid)
      begin
        if (ld_tmr)
        begin
          compare_value("timer load latency", 64'd2, 64'(tmr_cycles));
          tmr_busy = 1'b0;
          if (load_req_i.addr == `MTIME_ADDR_HI)
            compare_value("load_rsp_o.data", 64'd0, 64'(load_rsp_i.data));
          else
          begin
            checks++;
            if (have_lo && load_rsp_i.data <= last_lo)
              report_failure("timer low word did not increase between reads");
            last_lo = load_rsp_i.data;
            have_lo = 1'b1;
          end
        end
        else
          compare_value("load_rsp_o.data",
                        64'(ref_read(shadow[load_req_i.addr[10:3]], load_req_i.addr)),
                        64'(load_rsp_i.data));
      end
    end
  end

endmodule

`default_nettype wire

// File: verif/tb_top.sv
`include "bus_config.svh"
`default_nettype none

module tb_top;

  import axi_pkg::*;
  import core_bus_pkg::*;

  localparam int NUM_TXN        = 45;
  localparam int CYCLES_PER_TXN = 40;

  logic       clk = 1'b0;
  logic       rst = 1'b1;
  fetch_req_t fetch_req = '0;
  load_req_t  load_req = '0;
  store_req_t store_req = '0;
  core_rsp_t  fetch_rsp;
  core_rsp_t  load_rsp;
  logic       store_done;
  logic       bus_err;
  axi_ar_t    ar;
  logic       arvalid;
  logic       arready = 1'b0;
  axi_r_t     r = '0;
  logic       rvalid = 1'b0;
  logic       rready;
  axi_aw_t    aw;
  logic       awvalid;
  logic       awready = 1'b0;
  axi_w_t     w;
  logic       wvalid;
  logic       wready = 1'b0;
  axi_b_t     b = '0;
  logic       bvalid = 1'b0;
  logic       bready;
  int         err_count;
  int         check_count;

  // slave memory model state
  logic [63:0] mem [0:255];
  integer      seed = 32'h5c43b616;
  logic        ar_hs = 1'b0;
  logic        aw_hs = 1'b0;
  logic        w_hs = 1'b0;
  logic        aw_got = 1'b0;
  logic        w_got = 1'b0;
  logic        rd_busy = 1'b0;
  logic        wr_busy = 1'b0;
  logic [31:0] rd_addr = '0;
  logic [31:0] wr_addr = '0;
  logic [63:0] wr_data = '0;
  logic [7:0]  wr_strb = '0;
  int          rd_wait = 0;
  int          wr_wait = 0;

  core_bus_top u_dut (
    .clk           (clk),
    .rst           (rst),
    .fetch_req_i   (fetch_req),
    .load_req_i    (load_req),
    .store_req_i   (store_req),
    .fetch_rsp_o   (fetch_rsp),
    .load_rsp_o    (load_rsp),
    .store_done_o  (store_done),
    .bus_err_o     (bus_err),
    .bus_ar_o      (ar),
    .bus_arvalid_o (arvalid),
    .bus_arready_i (arready),
    .bus_r_i       (r),
    .bus_rvalid_i  (rvalid),
    .bus_rready_o  (rready),
    .bus_aw_o      (aw),
    .bus_awvalid_o (awvalid),
    .bus_awready_i (awready),
    .bus_w_o       (w),
    .bus_wvalid_o  (wvalid),
    .bus_wready_i  (wready),
    .bus_b_i       (b),
    .bus_bvalid_i  (bvalid),
    .bus_bready_o  (bready)
  );

  bus_checker u_chk (
    .clk           (clk),
    .rst           (rst),
    .fetch_req_i   (fetch_req),
    .load_req_i    (load_req),
    .store_req_i   (store_req),
    .fetch_rsp_i   (fetch_rsp),
    .load_rsp_i    (load_rsp),
    .store_done_i  (store_done),
    .bus_err_i     (bus_err),
    .ar_i          (ar),
    .arvalid_i     (arvalid),
    .arready_i     (arready),
    .r_i           (r),
    .rvalid_i      (rvalid),
    .rready_i      (rready),
    .aw_i          (aw),
    .awvalid_i     (awvalid),
    .awready_i     (awready),
    .w_i           (w),
    .wvalid_i      (wvalid),
    .wready_i      (wready),
    .b_i           (b),
    .bvalid_i      (bvalid),
    .bready_i      (bready),
    .err_count_o   (err_count),
    .check_count_o (check_count)
  );

  initial
  begin
    forever #50 clk = ~clk;
  end

  // each word built from its full byte address
  function automatic logic [63:0] fill_word(input int idx);
    logic [31:0] a;
    a = idx * 8;
    return {(a + 32'd4) * 32'h9E37_79B9, a * 32'h9E37_79B9};
  endfunction

  function automatic axi_resp_e resp_for(input logic [31:0] addr);
    return (addr[11:8] == 4'hF) ? SLVERR : OKAY;  // error window
  endfunction

  initial
  begin
    for (int i = 0; i < 256; i++)
      mem[i] = fill_word(i);
  end

  // slave model decides on the falling edge
  always @(negedge clk)
  begin
    if (rvalid)
      rvalid = 1'b0;
    if (ar_hs)
    begin
      rd_busy = 1'b1;
      rd_wait = $random(seed) & 3;
    end
    if (rd_busy)
    begin
      if (rd_wait == 0)
      begin
        rd_busy = 1'b0;
        rvalid  = 1'b1;
        r = '{data: mem[rd_addr[10:3]], resp: resp_for(rd_addr), last: 1'b1, id: '0};
      end
      else
        rd_wait = rd_wait - 1;
    end
    arready = ($random(seed) & 3) != 0;
    ar_hs   = arvalid && arready;  // beat lands on the next rising edge
    if (ar_hs)
      rd_addr = ar.addr;

    if (bvalid)
      bvalid = 1'b0;
    if (aw_hs)
      aw_got = 1'b1;
    if (w_hs)
      w_got = 1'b1;
    if (aw_got && w_got && !wr_busy)
    begin
      wr_busy = 1'b1;
      wr_wait = $random(seed) & 3;
    end
    if (wr_busy)
    begin
      if (wr_wait == 0)
      begin
        if (resp_for(wr_addr) == OKAY)
        begin
          for (int k = 0; k < 8; k++)
            if (wr_strb[k])
              mem[wr_addr[10:3]][8*k +: 8] = wr_data[8*k +: 8];
        end
        bvalid  = 1'b1;
        b       = '{resp: resp_for(wr_addr), id: '0};
        wr_busy = 1'b0;
        aw_got  = 1'b0;
        w_got   = 1'b0;
      end
      else
        wr_wait = wr_wait - 1;
    end
    awready = ($random(seed) & 3) != 0;
    wready  = ($random(seed) & 3) != 0;
    aw_hs   = awvalid && awready;
    w_hs    = wvalid && wready;
    if (aw_hs)
      wr_addr = aw.addr;
    if (w_hs)
    begin
      wr_data = w.data;
      wr_strb = w.strb;
    end
  end

  task automatic run_fetch(input logic [31:0] a);
    @(negedge clk);
    fetch_req = '{addr: a, valid: 1'b1};
    @(posedge clk);
    while (!fetch_rsp.valid)
      @(posedge clk);
    @(negedge clk);
    fetch_req.valid = 1'b0;
  endtask

  task automatic run_load(input logic [31:0] a, input logic [3:0] s);
    @(negedge clk);
    load_req = '{addr: a, strb: s, valid: 1'b1};
    @(posedge clk);
    while (!load_rsp.valid)
      @(posedge clk);
    @(negedge clk);
    load_req.valid = 1'b0;
  endtask

  task automatic run_store(input logic [31:0] a, input logic [31:0] d, input logic [3:0] s);
    @(negedge clk);
    store_req = '{addr: a, data: d, strb: s, valid: 1'b1};
    @(posedge clk);
    while (!store_done)
      @(posedge clk);
    @(negedge clk);
    store_req.valid = 1'b0;
  endtask

  // load and fetch raised in the same cycle
  task automatic run_load_with_fetch(input logic [31:0] la, input logic [31:0] fa);
    @(negedge clk);
    load_req  = '{addr: la, strb: 4'b1111, valid: 1'b1};
    fetch_req = '{addr: fa, valid: 1'b1};
    @(posedge clk);
    while (!load_rsp.valid)
      @(posedge clk);
    @(negedge clk);
    load_req.valid = 1'b0;
    @(posedge clk);
    while (!fetch_rsp.valid)
      @(posedge clk);
    @(negedge clk);
    fetch_req.valid = 1'b0;
  endtask

  initial
  begin
    logic [31:0] base;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    for (int i = 0; i < 8; i++)
      run_fetch(i * 4);

    for (int h = 0; h < 2; h++)
    begin
      base = 32'h0000_0100 + h * 4;
      for (int o = 0; o < 4; o++)
      begin
        run_store(base + o, $random(seed), 4'b0001);
        run_load(base, 4'b1111);
      end
      for (int o = 0; o < 4; o += 2)
      begin
        run_store(base + o, $random(seed), 4'b0011);
        run_load(base, 4'b1111);
      end
      run_store(base, $random(seed), 4'b1111);
      run_load(base, 4'b1111);
    end

    run_load_with_fetch(32'h0000_0108, 32'h0000_0020);

    repeat (4)
      run_load(`MTIME_ADDR, 4'b1111);
    run_load(`MTIME_ADDR_HI, 4'b1111);

    // error window at 0xF00
    run_fetch(32'h0000_0F00);
    run_store(32'h0000_0F08, $random(seed), 4'b1111);

    repeat (4) @(negedge clk);
    $display("checks: %0d, errors: %0d", check_count, err_count);
    if (err_count == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

  initial
  begin
    repeat (NUM_TXN * CYCLES_PER_TXN + 10) @(posedge clk);
    $display("watchdog expired, a transaction never completed");
    $display("TEST FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: files.f
+incdir+hw
hw/axi_pkg.sv
hw/core_bus_pkg.sv
hw/clint_timer.sv
hw/lane_align.sv
hw/mem_arbiter.sv
hw/core_bus_top.sv
verif/bus_checker.sv
verif/tb_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_top -f files.f -o sim_tb
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^TEST PASS$" sim.log; then
  exit 0
fi
echo "pass message not found in sim.log"
exit 1
